/* all.f */
verilog/unit_mux_pkg.sv
verilog/unit_dispatch.sv
verilog/exec_lane.sv
verilog/result_collect.sv
verilog/unit_mux_top.sv
bench/unit_mux_props.sv
bench/unit_mux_tb.sv

/* bench/unit_mux_props.sv */
/*
 * Handshake properties for unit_mux_top, bound to every instance of it.
 * The outstanding count assumes the DUT starts empty when reset is released.
 */

`timescale 1ns/1ps

module unit_mux_props (
        input  logic                                clk_i,
        input  logic                                reset_i,
        input  logic                                in_valid_i,
        input  logic                                in_ready_o,
        input  logic                                out_valid_o,
        input  logic                                out_ready_i,
        input  logic    [unit_mux_pkg::ID_W  -1:0]  out_id_o,
        input  logic    [unit_mux_pkg::DATA_W-1:0]  out_data_o
    );

    int outstanding;

    // Accepted minus retired operations
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(in_valid_i & in_ready_o)
                                       - int'(out_valid_o & out_ready_i);
        end
    end

    ready_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> in_ready_o)
        else $error("in_ready_o low in the first cycle after reset");

    // First edge of reset still sees uninitialised state
    idle_in_reset: assert property (@(posedge clk_i) reset_i && $past(reset_i) |-> !out_valid_o)
        else $error("out_valid_o high during reset");

    output_held: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_id_o) && $stable(out_data_o))
        else $error("Output changed while stalled");

    no_spurious_output: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o && out_ready_i |-> outstanding != 0)
        else $error("Output transfer with no operation outstanding");

endmodule

bind unit_mux_top unit_mux_props props (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_id_o    ( out_id_o    ),
    .out_data_o  ( out_data_o  )
);

/* bench/unit_mux_tb.sv */
/*
 * Random and directed traffic through unit_mux_top with an in-order scoreboard.
 * Stops at the first mismatch; run length is bounded by a cycle counter.
 */

`timescale 1ns/1ps

module unit_mux_tb;

    import unit_mux_pkg::*;

    localparam int NUM_RANDOM  = 600;
    // 600 random operations at about 30 cycles each in the worst stall pattern
    localparam int CYCLE_LIMIT = 20000;
    // A full order queue retires well within this with the output always ready
    localparam int DRAIN_LIMIT = 8 * ORDER_DEPTH;

    logic                 clk_i;
    logic                 reset_i;
    logic                 in_valid_i;
    logic                 in_ready_o;
    logic [LANE_W-1:0]    in_lane_i;
    logic [ID_W-1:0]      in_id_i;
    alu_op_e              in_op_i;
    elem_width_e          in_ew_i;
    logic [DATA_W-1:0]    in_a_i;
    logic [DATA_W-1:0]    in_b_i;
    logic                 out_valid_o;
    logic                 out_ready_i;
    logic [ID_W-1:0]      out_id_o;
    logic [DATA_W-1:0]    out_data_o;

    integer               seed = 32'ha20e_f653;
    bit                   random_ready;
    int                   cycles;
    logic [ID_W-1:0]      exp_id_q[$];
    logic [DATA_W-1:0]    exp_data_q[$];
    logic [ID_W-1:0]      want_id;
    logic [DATA_W-1:0]    want_data;

    unit_mux_top uut (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [DATA_W-1:0] expected_result(input alu_op_e op,
            input elem_width_e ew, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] res;
        logic [7:0]        x;
        logic [7:0]        y;
        res = '0;
        if (ew == EW32) begin
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_XOR:  res = a ^ b;
                default: res = (a > b) ? a : b;
            endcase
        end else begin
            for (int k = 0; k < 4; k++) begin
                x = a[8*k +: 8];
                y = b[8*k +: 8];
                case (op)
                    OP_ADD:  res[8*k +: 8] = x + y;
                    OP_SUB:  res[8*k +: 8] = x - y;
                    OP_XOR:  res[8*k +: 8] = x ^ y;
                    default: res[8*k +: 8] = (x > y) ? x : y;
                endcase
            end
        end
        return res;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    // One clock; reports whether the driven operation was taken at this edge
    task automatic tick(output bit taken);
        @(posedge clk_i);
        taken = in_valid_i & in_ready_o;
        #1;
        if (random_ready) begin
            out_ready_i = ($unsigned($random(seed)) % 3) != 0;
        end
    endtask

    task automatic send_op(input logic [LANE_W-1:0] lane, input logic [ID_W-1:0] id,
            input alu_op_e op, input elem_width_e ew, input logic [DATA_W-1:0] a,
            input logic [DATA_W-1:0] b);
        bit taken;
        in_lane_i  = lane;
        in_id_i    = id;
        in_op_i    = op;
        in_ew_i    = ew;
        in_a_i     = a;
        in_b_i     = b;
        in_valid_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            tick(taken);
        end
        in_valid_i = 1'b0;
    endtask

    task automatic drive_random(input logic [LANE_W-1:0] lane);
        logic [31:0] r;
        r         = $random(seed);
        in_lane_i = lane;
        in_id_i   = r[2:0];
        in_op_i   = alu_op_e'(r[4:3]);
        in_ew_i   = elem_width_e'(r[5]);
        in_a_i    = $random(seed);
        in_b_i    = $random(seed);
    endtask

    // Output stalled from reset, so only ORDER_DEPTH operations fit
    task automatic fill_without_drain();
        int n;
        bit taken;
        n           = 0;
        out_ready_i = 1'b0;
        drive_random(LANE_W'(n));
        in_valid_i  = 1'b1;
        repeat (12) begin
            tick(taken);
            if (taken) begin
                n++;
                drive_random(LANE_W'(n));
            end
        end
        check_value("operations accepted while stalled", n, ORDER_DEPTH);
        check_value("in_ready_o with full queue", in_ready_o, 1'b0);
        out_ready_i = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            tick(taken);
        end
        in_valid_i = 1'b0;
    endtask

    // Waits for every accepted operation to retire, up to DRAIN_LIMIT cycles
    task automatic drain();
        bit taken;
        int waited;
        waited = 0;
        while (exp_id_q.size() != 0 && waited < DRAIN_LIMIT) begin
            tick(taken);
            waited++;
        end
    endtask

    // Scoreboard entry for every accepted operation
    always @(posedge clk_i) begin
        if (!reset_i && in_valid_i && in_ready_o) begin
            exp_id_q.push_back(in_id_i);
            exp_data_q.push_back(expected_result(in_op_i, in_ew_i, in_a_i, in_b_i));
        end
    end

    always @(posedge clk_i) begin
        if (!reset_i && out_valid_o && out_ready_i) begin
            if (exp_id_q.size() == 0) begin
                report_failure("Result came out with no accepted operation left to match it");
            end else begin
                want_id   = exp_id_q.pop_front();
                want_data = exp_data_q.pop_front();
                check_value("out_id_o", out_id_o, want_id);
                check_value("out_data_o", out_data_o, want_data);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            report_failure("Timeout: the test did not finish within the cycle limit");
        end
    end

    initial begin
        bit taken;
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        in_valid_i   = 1'b0;
        in_lane_i    = '0;
        in_id_i      = '0;
        in_op_i      = OP_ADD;
        in_ew_i      = EW32;
        in_a_i       = '0;
        in_b_i       = '0;
        out_ready_i  = 1'b0;
        random_ready = 1'b0;
        cycles       = 0;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        fill_without_drain();
        drain();

        // Word wraparound, byte isolation and unsigned maximum
        send_op(2'd0, 3'd0, OP_ADD,  EW32, 32'hFFFF_FFFF, 32'h0000_0002);
        send_op(2'd1, 3'd1, OP_SUB,  EW32, 32'h0000_0000, 32'h0000_0001);
        send_op(2'd2, 3'd2, OP_XOR,  EW32, 32'hA5A5_5A5A, 32'hFFFF_0000);
        send_op(2'd3, 3'd3, OP_MAXU, EW32, 32'h8000_0000, 32'h7FFF_FFFF);
        send_op(2'd0, 3'd4, OP_ADD,  EW8,  32'h00FF_80FF, 32'h0001_8001);
        send_op(2'd1, 3'd5, OP_SUB,  EW8,  32'h0000_0000, 32'h0101_0101);
        send_op(2'd2, 3'd6, OP_XOR,  EW8,  32'h1234_5678, 32'h0F0F_F0F0);
        send_op(2'd3, 3'd7, OP_MAXU, EW8,  32'h807F_01FE, 32'h7F80_FE01);
        drain();

        random_ready = 1'b1;
        repeat (NUM_RANDOM) begin
            drive_random(LANE_W'($unsigned($random(seed)) % LANE_CNT));
            send_op(in_lane_i, in_id_i, in_op_i, in_ew_i, in_a_i, in_b_i);
            if (($unsigned($random(seed)) % 4) == 0) begin
                tick(taken);
            end
        end
        random_ready = 1'b0;
        out_ready_i  = 1'b1;
        drain();

        if (exp_id_q.size() != 0) begin
            report_failure("Scoreboard still holds operations at the end of the test");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* verilog/exec_lane.sv */
/*
 * Two-stage lane: stage one registers the operation, stage two registers the result.
 * EW8 works on four bytes with no carry or borrow between them.
 */

`timescale 1ns/1ps

module exec_lane (
        input  logic                               clk_i,
        input  logic                               reset_i,

        input  logic                               in_valid_i,
        output logic                               in_ready_o,
        input  logic    [unit_mux_pkg::ID_W-1:0]   in_id_i,
        input  unit_mux_pkg::alu_op_e              in_op_i,
        input  unit_mux_pkg::elem_width_e          in_ew_i,
        input  unit_mux_pkg::data_word_u           in_a_i,
        input  unit_mux_pkg::data_word_u           in_b_i,

        output logic                               out_valid_o,
        input  logic                               out_ready_i,
        output logic    [unit_mux_pkg::ID_W-1:0]   out_id_o,
        output unit_mux_pkg::data_word_u           out_data_o
    );

    import unit_mux_pkg::*;

    logic              s1_valid;
    logic [ID_W-1:0]   s1_id;
    alu_op_e           s1_op;
    elem_width_e       s1_ew;
    data_word_u        s1_a;
    data_word_u        s1_b;
    data_word_u        s1_res;

    logic              s2_valid;
    logic              s2_ready;
    logic              s1_advance;
    logic              in_fire;

    // Stage two drains when empty or when the collector takes its result
    assign s2_ready   = ~s2_valid | out_ready_i;
    assign s1_advance = s1_valid & s2_ready;
    assign in_ready_o = ~s1_valid | s2_ready;
    assign in_fire    = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                s1_valid <= 1'b1;
            end else if (s1_advance) begin
                s1_valid <= 1'b0;
            end
            if (s1_advance) begin
                s2_valid <= 1'b1;
            end else if (out_ready_i) begin
                s2_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            s1_id <= in_id_i;
            s1_op <= in_op_i;
            s1_ew <= in_ew_i;
            s1_a  <= in_a_i;
            s1_b  <= in_b_i;
        end
        if (s1_advance) begin
            out_id_o   <= s1_id;
            out_data_o <= s1_res;
        end
    end

    always_comb begin
        s1_res = '0;
        if (s1_ew == EW32) begin
            case (s1_op)
                OP_ADD:  s1_res.word = s1_a.word + s1_b.word;
                OP_SUB:  s1_res.word = s1_a.word - s1_b.word;
                OP_XOR:  s1_res.word = s1_a.word ^ s1_b.word;
                default: s1_res.word = (s1_a.word > s1_b.word) ? s1_a.word : s1_b.word;
            endcase
        end else begin
            // Each byte wraps on its own
            for (int i = 0; i < DATA_W / 8; i++) begin
                case (s1_op)
                    OP_ADD:  s1_res.bytes[i] = s1_a.bytes[i] + s1_b.bytes[i];
                    OP_SUB:  s1_res.bytes[i] = s1_a.bytes[i] - s1_b.bytes[i];
                    OP_XOR:  s1_res.bytes[i] = s1_a.bytes[i] ^ s1_b.bytes[i];
                    default: s1_res.bytes[i] = (s1_a.bytes[i] > s1_b.bytes[i]) ?
                                               s1_a.bytes[i] : s1_b.bytes[i];
                endcase
            end
        end
    end

    assign out_valid_o = s2_valid;

endmodule

/* verilog/result_collect.sv */
/*
 * Passes out only the result of the lane at the queue head; idle outputs are zero.
 */

`timescale 1ns/1ps

module result_collect (
        input  logic                                                          head_valid_i,
        input  logic    [unit_mux_pkg::LANE_W-1:0]                            head_lane_i,

        input  logic    [unit_mux_pkg::LANE_CNT-1:0]                          lane_out_valid_i,
        output logic    [unit_mux_pkg::LANE_CNT-1:0]                          lane_out_ready_o,
        input  logic    [unit_mux_pkg::LANE_CNT-1:0][unit_mux_pkg::ID_W  -1:0] lane_out_id_i,
        input  logic    [unit_mux_pkg::LANE_CNT-1:0][unit_mux_pkg::DATA_W-1:0] lane_out_data_i,

        output logic                                                          out_valid_o,
        input  logic                                                          out_ready_i,
        output logic    [unit_mux_pkg::ID_W  -1:0]                            out_id_o,
        output logic    [unit_mux_pkg::DATA_W-1:0]                            out_data_o,

        output logic                                                          pop_o
    );

    import unit_mux_pkg::*;

    // Lanes other than the head stay stalled, which keeps retirement in order
    always_comb begin
        out_valid_o      = 1'b0;
        out_id_o         = '0;
        out_data_o       = '0;
        lane_out_ready_o = '0;
        for (int i = 0; i < LANE_CNT; i++) begin
            if (head_valid_i && (head_lane_i == LANE_W'(i))) begin
                lane_out_ready_o[i] = out_ready_i;
                out_valid_o         = lane_out_valid_i[i];
                if (lane_out_valid_i[i]) begin
                    out_id_o   = lane_out_id_i[i];
                    out_data_o = lane_out_data_i[i];
                end
            end
        end
    end

    assign pop_o = out_valid_o & out_ready_i;

endmodule

/* verilog/unit_dispatch.sv */
/*
 * Routes each operation to the lane it names and records that lane in an in-order queue.
 * An operation is taken only while the queue has room; pop_i must only come with a valid head.
 */

`timescale 1ns/1ps

module unit_dispatch (
        input  logic                                   clk_i,
        input  logic                                   reset_i,

        input  logic                                   in_valid_i,
        output logic                                   in_ready_o,
        input  logic    [unit_mux_pkg::LANE_W   -1:0]  in_lane_i,

        output logic    [unit_mux_pkg::LANE_CNT -1:0]  lane_in_valid_o,
        input  logic    [unit_mux_pkg::LANE_CNT -1:0]  lane_in_ready_i,

        output logic                                   head_valid_o,
        output logic    [unit_mux_pkg::LANE_W   -1:0]  head_lane_o,
        input  logic                                   pop_i
    );

    import unit_mux_pkg::*;

    localparam int unsigned PTR_W = $clog2(ORDER_DEPTH);
    localparam int unsigned CNT_W = $clog2(ORDER_DEPTH + 1);

    logic [LANE_W-1:0] order_q [ORDER_DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              queue_full;
    logic              push;

    assign queue_full = (count == CNT_W'(ORDER_DEPTH));

    // Only the named lane sees the valid, and only while the queue can record it
    always_comb begin
        lane_in_valid_o = '0;
        in_ready_o      = ~queue_full & lane_in_ready_i[in_lane_i];
        if (in_valid_i) begin
            lane_in_valid_o[in_lane_i] = ~queue_full;
        end
    end

    assign push = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_i})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // Queue storage holds lane indices only
    always_ff @(posedge clk_i) begin
        if (push) begin
            order_q[wr_ptr] <= in_lane_i;
        end
    end

    assign head_valid_o = (count != '0);
    assign head_lane_o  = order_q[rd_ptr];

endmodule

/* verilog/unit_mux_pkg.sv */
/*
 * Shared widths, opcodes and the data word view for the vector back end.
 * ORDER_DEPTH must stay a power of two, since the order queue pointers wrap naturally.
 */

package unit_mux_pkg;

    // Lane count and lane index width go together
    localparam int unsigned LANE_CNT    = 4;
    localparam int unsigned LANE_W      = 2;

    localparam int unsigned ID_W        = 3;
    localparam int unsigned DATA_W      = 32;

    // Also the limit on operations in flight across all lanes
    localparam int unsigned ORDER_DEPTH = 4;

    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_XOR  = 2'd2,
        OP_MAXU = 2'd3
    } alu_op_e;

    // EW32 is one full word, EW8 is four independent bytes
    typedef enum logic {
        EW32 = 1'b0,
        EW8  = 1'b1
    } elem_width_e;

    // Operand and result word, read either whole or byte by byte
    typedef union packed {
        logic [DATA_W-1:0]             word;
        logic [DATA_W/8-1:0][7:0]      bytes;
    } data_word_u;

endpackage

/* verilog/unit_mux_top.sv */
/*
 * Four lanes behind one in-order issue and retire port.
 * Results leave in acceptance order; at most ORDER_DEPTH operations are in flight.
 */

`timescale 1ns/1ps

module unit_mux_top (
        input  logic                                  clk_i,
        input  logic                                  reset_i,

        input  logic                                  in_valid_i,
        output logic                                  in_ready_o,
        input  logic    [unit_mux_pkg::LANE_W-1:0]    in_lane_i,
        input  logic    [unit_mux_pkg::ID_W  -1:0]    in_id_i,
        input  unit_mux_pkg::alu_op_e                 in_op_i,
        input  unit_mux_pkg::elem_width_e             in_ew_i,
        input  logic    [unit_mux_pkg::DATA_W-1:0]    in_a_i,
        input  logic    [unit_mux_pkg::DATA_W-1:0]    in_b_i,

        output logic                                  out_valid_o,
        input  logic                                  out_ready_i,
        output logic    [unit_mux_pkg::ID_W  -1:0]    out_id_o,
        output logic    [unit_mux_pkg::DATA_W-1:0]    out_data_o
    );

    import unit_mux_pkg::*;

    logic [LANE_CNT-1:0]             lane_in_valid;
    logic [LANE_CNT-1:0]             lane_in_ready;
    logic [LANE_CNT-1:0]             lane_out_valid;
    logic [LANE_CNT-1:0]             lane_out_ready;
    logic [LANE_CNT-1:0][ID_W  -1:0] lane_out_id;
    logic [LANE_CNT-1:0][DATA_W-1:0] lane_out_data;

    logic                            head_valid;
    logic [LANE_W-1:0]               head_lane;
    logic                            pop;

    unit_dispatch dispatch (
        .clk_i            ( clk_i          ),
        .reset_i          ( reset_i        ),
        .in_valid_i       ( in_valid_i     ),
        .in_ready_o       ( in_ready_o     ),
        .in_lane_i        ( in_lane_i      ),
        .lane_in_valid_o  ( lane_in_valid  ),
        .lane_in_ready_i  ( lane_in_ready  ),
        .head_valid_o     ( head_valid     ),
        .head_lane_o      ( head_lane      ),
        .pop_i            ( pop            )
    );

    // Operation fields go to every lane; only the lane with its valid high takes them
    generate
        for (genvar i = 0; i < LANE_CNT; i++) begin : g_lane
            exec_lane lane (
                .clk_i        ( clk_i             ),
                .reset_i      ( reset_i           ),
                .in_valid_i   ( lane_in_valid [i] ),
                .in_ready_o   ( lane_in_ready [i] ),
                .in_id_i      ( in_id_i           ),
                .in_op_i      ( in_op_i           ),
                .in_ew_i      ( in_ew_i           ),
                .in_a_i       ( in_a_i            ),
                .in_b_i       ( in_b_i            ),
                .out_valid_o  ( lane_out_valid[i] ),
                .out_ready_i  ( lane_out_ready[i] ),
                .out_id_o     ( lane_out_id   [i] ),
                .out_data_o   ( lane_out_data [i] )
            );
        end
    endgenerate

    result_collect collect (
        .head_valid_i     ( head_valid     ),
        .head_lane_i      ( head_lane      ),
        .lane_out_valid_i ( lane_out_valid ),
        .lane_out_ready_o ( lane_out_ready ),
        .lane_out_id_i    ( lane_out_id    ),
        .lane_out_data_i  ( lane_out_data  ),
        .out_valid_o      ( out_valid_o    ),
        .out_ready_i      ( out_ready_i    ),
        .out_id_o         ( out_id_o       ),
        .out_data_o       ( out_data_o     ),
        .pop_o            ( pop            )
    );

endmodule
